// ==== build.f ====
+incdir+include
rtl/copy_pkg.sv
rtl/sync_fifo.sv
rtl/beat_counter.sv
rtl/copy_fsm.sv
rtl/axi_copy_engine.sv
testbench/axi_slave_mem.sv
testbench/tb_axi_copy_engine.sv

// ==== run_sim.sh ====
#!/bin/sh
# build and run the copy engine testbench with Verilator
set -e

cd "$(dirname "$0")"

verilator --binary --timing -j 0 \
	-f build.f \
	--top-module tb_axi_copy_engine \
	-o sim_tb

./obj_dir/sim_tb > sim.log 2>&1
cat sim.log

if grep -q "Testbench passed" sim.log; then
	echo "simulation ok"
	exit 0
else
	echo "simulation reported failure"
	exit 1
fi

// ==== testbench/tb_axi_copy_engine.sv ====
`timescale 1ns/100ps
`include "copy_cfg.svh"

module tb_axi_copy_engine
	import copy_pkg::*;
();

	logic m_axi_aclk;
	logic rst_n;

	logic cmd_valid;
	logic cmd_ready;
	logic [`COPY_ADDR_W-1:0] cmd_src_addr;
	logic [`COPY_ADDR_W-1:0] cmd_dst_addr;
	logic [LEN_W-1:0] cmd_len;
	logic [`COPY_ID_W-1:0] cmd_id;

	logic done_valid;
	logic done_ready;
	logic [`COPY_ID_W-1:0] done_id;
	logic [1:0] done_resp;

	logic [`COPY_ADDR_W-1:0] m_axi_awaddr;
	logic m_axi_awvalid;
	logic m_axi_awready;
	logic [`COPY_ID_W-1:0] m_axi_awid;
	logic [7:0] m_axi_awlen;
	logic [2:0] m_axi_awsize;
	logic [1:0] m_axi_awburst;
	logic [`COPY_ID_W-1:0] m_axi_wid;
	logic [`COPY_DATA_W-1:0] m_axi_wdata;
	logic [`COPY_DATA_W/8-1:0] m_axi_wstrb;
	logic m_axi_wvalid;
	logic m_axi_wready;
	logic m_axi_wlast;
	logic m_axi_bready;
	logic [1:0] m_axi_bresp;
	logic m_axi_bvalid;
	logic [`COPY_ADDR_W-1:0] m_axi_araddr;
	logic m_axi_arvalid;
	logic m_axi_arready;
	logic [`COPY_ID_W-1:0] m_axi_arid;
	logic [7:0] m_axi_arlen;
	logic [2:0] m_axi_arsize;
	logic [1:0] m_axi_arburst;
	logic m_axi_rready;
	logic [`COPY_DATA_W-1:0] m_axi_rdata;
	logic [1:0] m_axi_rresp;
	logic m_axi_rvalid;
	logic m_axi_rlast;

	logic stall_en;
	// 0 always ready, 1 random, 2 held low
	logic [1:0] done_mode;

	int errors;
	int test_start_errors;
	int tests_run;
	string cur_test;
	bit timed_out;

	logic [`COPY_ID_W-1:0] exp_id_q[$];
	logic [1:0] exp_resp_q[$];
	int dst_q[$];
	int len_q[$];
	// expected memory image, copies applied in command order
	logic [`COPY_DATA_W-1:0] exp_mem [1024];

	axi_copy_engine axi_copy_engine_inst (.*);

	axi_slave_mem slave_mem (
		.m_axi_aclk(m_axi_aclk),
		.rst_n(rst_n),
		.stall_en(stall_en),
		.awaddr(m_axi_awaddr),
		.awlen(m_axi_awlen),
		.awvalid(m_axi_awvalid),
		.awready(m_axi_awready),
		.wdata(m_axi_wdata),
		.wvalid(m_axi_wvalid),
		.wlast(m_axi_wlast),
		.wready(m_axi_wready),
		.bresp(m_axi_bresp),
		.bvalid(m_axi_bvalid),
		.bready(m_axi_bready),
		.araddr(m_axi_araddr),
		.arlen(m_axi_arlen),
		.arvalid(m_axi_arvalid),
		.arready(m_axi_arready),
		.rdata(m_axi_rdata),
		.rresp(m_axi_rresp),
		.rvalid(m_axi_rvalid),
		.rlast(m_axi_rlast),
		.rready(m_axi_rready)
	);

	initial begin
		m_axi_aclk = 1'b0;
		forever #4 m_axi_aclk = ~m_axi_aclk;
	end

	function automatic bit in_error_window(input int first, input int len);
		return (first <= 'h30F) && (first + len - 1 >= 'h300);
	endfunction

	// bresp error first, then rresp error, else okay
	function automatic logic [1:0] expected_resp(input int src_w, input int dst_w, input int len);
		if (in_error_window(dst_w, len)) begin
			return RESP_SLVERR;
		end else if (in_error_window(src_w, len)) begin
			return RESP_SLVERR;
		end
		return RESP_OKAY;
	endfunction

	task automatic check_value(input string what, input logic [31:0] expected,
			input logic [31:0] actual);
		if (expected !== actual) begin
			errors++;
			$display("[FAIL] %s %s: expected %0h, actual %0h", cur_test, what, expected,
				actual);
		end
	endtask

	task automatic note_timeout(input string why);
		errors++;
		timed_out = 1'b1;
		$display("timeout: %s", why);
	endtask

	task automatic start_test(input string name);
		cur_test = name;
		test_start_errors = errors;
		tests_run++;
	endtask

	task automatic end_test();
		$display("test %s: %s", cur_test, (errors == test_start_errors) ? "ok" : "errors");
	endtask

	// caller sits just after a rising edge; cmd_valid stays high on return
	task automatic send_cmd(input int src_w, input int dst_w, input int len,
			input logic [`COPY_ID_W-1:0] id);
		int t;
		if (!timed_out) begin
			cmd_valid <= 1'b1;
			cmd_src_addr <= 32'(src_w * 4);
			cmd_dst_addr <= 32'(dst_w * 4);
			cmd_len <= LEN_W'(len);
			cmd_id <= id;
			exp_id_q.push_back(id);
			exp_resp_q.push_back(expected_resp(src_w, dst_w, len));
			dst_q.push_back(dst_w);
			len_q.push_back(len);
			for (int i = 0; i < len; i++) begin
				exp_mem[dst_w + i] = exp_mem[src_w + i];
			end
			for (t = 0; t < 2000; t++) begin
				@(posedge m_axi_aclk);
				if (cmd_ready) break;
			end
			if (t == 2000) note_timeout("command never accepted");
		end
	endtask

	task automatic wait_all_done();
		int t;
		for (t = 0; t < 20000 && exp_id_q.size() != 0 && !timed_out; t++) begin
			@(posedge m_axi_aclk);
		end
		if (exp_id_q.size() != 0 && !timed_out) note_timeout("done records still missing");
	endtask

	task automatic check_memory();
		int d;
		for (int k = 0; k < dst_q.size(); k++) begin
			d = dst_q[k];
			for (int i = 0; i < len_q[k]; i++) begin
				check_value($sformatf("dst word %0h", d + i), exp_mem[d + i],
					slave_mem.mem[d + i]);
			end
		end
		dst_q.delete();
		len_q.delete();
	endtask

	task automatic copy_one(input int src_w, input int dst_w, input int len,
			input logic [`COPY_ID_W-1:0] id);
		send_cmd(src_w, dst_w, len, id);
		cmd_valid <= 1'b0;
		wait_all_done();
	endtask

	always @(posedge m_axi_aclk) begin
		case (done_mode)
			2'd0: done_ready <= 1'b1;
			2'd1: done_ready <= ($urandom % 3 != 0);
			default: done_ready <= 1'b0;
		endcase
	end

	// done records must match the queue front
	always @(posedge m_axi_aclk) begin
		if (rst_n && done_valid && done_ready) begin
			if (exp_id_q.size() == 0) begin
				errors++;
				$display("%s: done record arrived with no command pending", cur_test);
			end else begin
				check_value("done_id", 32'(exp_id_q.pop_front()), 32'(done_id));
				check_value("done_resp", 32'(exp_resp_q.pop_front()), 32'(done_resp));
			end
		end
	end

	// the running command is the oldest one without a done record
	always @(posedge m_axi_aclk) begin
		if (rst_n && exp_id_q.size() != 0) begin
			// 4-byte beats, incrementing bursts
			if (m_axi_arvalid && m_axi_arready) begin
				check_value("arid", 32'(exp_id_q[0]), 32'(m_axi_arid));
				check_value("arsize", 2, 32'(m_axi_arsize));
				check_value("arburst", 1, 32'(m_axi_arburst));
			end
			if (m_axi_awvalid && m_axi_awready) begin
				check_value("awid", 32'(exp_id_q[0]), 32'(m_axi_awid));
				check_value("awsize", 2, 32'(m_axi_awsize));
				check_value("awburst", 1, 32'(m_axi_awburst));
			end
			if (m_axi_wvalid && m_axi_wready) begin
				check_value("wid", 32'(exp_id_q[0]), 32'(m_axi_wid));
				check_value("wstrb", 'hF, 32'(m_axi_wstrb));
			end
		end
	end

	initial begin
		int len;
		int src;
		int dst;
		void'($urandom(36522));
		errors = 0;
		tests_run = 0;
		timed_out = 1'b0;
		rst_n = 1'b0;
		cmd_valid = 1'b0;
		cmd_src_addr = '0;
		cmd_dst_addr = '0;
		cmd_len = '0;
		cmd_id = '0;
		done_ready = 1'b0;
		done_mode = 2'd0;
		stall_en = 1'b0;
		repeat (5) @(posedge m_axi_aclk);
		rst_n <= 1'b1;
		@(posedge m_axi_aclk);
		for (int i = 0; i < 1024; i++) begin
			exp_mem[i] = slave_mem.mem[i];
		end

		start_test("reset state");
		check_value("arvalid", 0, 32'(m_axi_arvalid));
		check_value("awvalid", 0, 32'(m_axi_awvalid));
		check_value("wvalid", 0, 32'(m_axi_wvalid));
		check_value("bready", 0, 32'(m_axi_bready));
		check_value("done_valid", 0, 32'(done_valid));
		check_value("cmd_ready", 1, 32'(cmd_ready));
		end_test();

		start_test("single copies");
		copy_one('h010, 'h100, 1, 4'd1);
		copy_one('h020, 'h120, 7, 4'd2);
		copy_one('h040, 'h140, 16, 4'd3);
		check_memory();
		end_test();

		start_test("random stalls");
		stall_en <= 1'b1;
		done_mode <= 2'd1;
		for (int n = 0; n < 12; n++) begin
			len = 1 + int'($urandom % 16);
			src = int'($urandom % 32'(257 - len));
			dst = 'h100 + int'($urandom % 32'(513 - len));
			send_cmd(src, dst, len, 4'($urandom % 16));
		end
		cmd_valid <= 1'b0;
		wait_all_done();
		check_memory();
		stall_en <= 1'b0;
		done_mode <= 2'd0;
		end_test();

		// done held low so the queue fills
		start_test("queue full");
		done_mode <= 2'd2;
		for (int n = 0; n < 5; n++) begin
			send_cmd('h080 + n * 8, 'h200 + n * 8, 8, 4'(n + 8));
		end
		cmd_valid <= 1'b0;
		@(posedge m_axi_aclk);
		check_value("cmd_ready", 0, 32'(cmd_ready));
		done_mode <= 2'd0;
		wait_all_done();
		check_memory();
		end_test();

		start_test("error window");
		copy_one('h2FC, 'h260, 8, 4'd5);
		copy_one('h030, 'h308, 4, 4'd6);
		copy_one('h050, 'h280, 5, 4'd7);
		check_memory();
		end_test();

		$display("%0d tests run, %0d failed checks", tests_run, errors);
		if (errors == 0) begin
			$display("Testbench passed");
		end else begin
			$display("Testbench failed");
		end
		$finish;
	end

endmodule

// ==== testbench/axi_slave_mem.sv ====
`timescale 1ns/100ps
`include "copy_cfg.svh"

module axi_slave_mem
	import copy_pkg::*;
(
	input logic m_axi_aclk,
	input logic rst_n,
	input logic stall_en,

	input logic [`COPY_ADDR_W-1:0] awaddr,
	input logic [7:0] awlen,
	input logic awvalid,
	output logic awready,

	input logic [`COPY_DATA_W-1:0] wdata,
	input logic wvalid,
	input logic wlast,
	output logic wready,

	output logic [1:0] bresp,
	output logic bvalid,
	input logic bready,

	input logic [`COPY_ADDR_W-1:0] araddr,
	input logic [7:0] arlen,
	input logic arvalid,
	output logic arready,

	output logic [`COPY_DATA_W-1:0] rdata,
	output logic [1:0] rresp,
	output logic rvalid,
	output logic rlast,
	input logic rready
);

	localparam int words = 1024;

	logic [`COPY_DATA_W-1:0] mem [words];

	logic rd_active;
	logic [9:0] rd_idx;
	logic [7:0] rd_left;
	logic rd_err;

	logic wr_active;
	logic b_pending;
	logic [9:0] wr_idx;
	logic wr_err;

	// random stall, one in four cycles
	function automatic logic ready_now();
		return !stall_en || ($urandom % 4 != 0);
	endfunction

	// bursts that touch words 0x300 to 0x30f fail
	function automatic logic err_window_hit(input logic [9:0] idx, input logic [7:0] len_m1);
		int first;
		int final_idx;
		first = int'(idx);
		final_idx = first + int'(len_m1);
		return (first <= 'h30F) && (final_idx >= 'h300);
	endfunction

	initial begin
		for (int i = 0; i < words; i++) begin
			mem[i] = (32'(i) << 16) ^ 32'(i) ^ 32'hC3A5_0F96;
		end
		awready = 1'b0;
		wready = 1'b0;
		bvalid = 1'b0;
		bresp = 2'd0;
		arready = 1'b0;
		rvalid = 1'b0;
		rlast = 1'b0;
		rresp = 2'd0;
		rdata = '0;
	end

	// read side
	always @(posedge m_axi_aclk) begin
		if (!rst_n) begin
			arready <= 1'b0;
			rvalid <= 1'b0;
			rlast <= 1'b0;
			rresp <= 2'd0;
			rd_active <= 1'b0;
		end else if (!rd_active) begin
			if (arvalid && arready) begin
				arready <= 1'b0;
				rd_active <= 1'b1;
				rd_idx <= araddr[11:2];
				rd_left <= arlen;
				rd_err <= err_window_hit(araddr[11:2], arlen);
			end else begin
				arready <= ready_now();
			end
		end else if (!rvalid || rready) begin
			if (rvalid && rlast) begin
				rvalid <= 1'b0;
				rlast <= 1'b0;
				rd_active <= 1'b0;
			end else if (ready_now()) begin
				rvalid <= 1'b1;
				rdata <= mem[rd_idx];
				rresp <= rd_err ? RESP_SLVERR : RESP_OKAY;
				rlast <= (rd_left == 8'd0);
				rd_idx <= rd_idx + 1'b1;
				rd_left <= rd_left - 1'b1;
			end else begin
				rvalid <= 1'b0;
			end
		end
	end

	// write side
	always @(posedge m_axi_aclk) begin
		if (!rst_n) begin
			awready <= 1'b0;
			wready <= 1'b0;
			bvalid <= 1'b0;
			bresp <= 2'd0;
			wr_active <= 1'b0;
			b_pending <= 1'b0;
		end else if (!wr_active) begin
			if (awvalid && awready) begin
				awready <= 1'b0;
				wr_active <= 1'b1;
				b_pending <= 1'b0;
				wr_idx <= awaddr[11:2];
				wr_err <= err_window_hit(awaddr[11:2], awlen);
			end else begin
				awready <= ready_now();
			end
		end else if (!b_pending) begin
			wready <= ready_now();
			if (wvalid && wready) begin
				mem[wr_idx] <= wdata;
				wr_idx <= wr_idx + 1'b1;
				if (wlast) begin
					wready <= 1'b0;
					b_pending <= 1'b1;
				end
			end
		end else if (!bvalid) begin
			bvalid <= ready_now();
			bresp <= wr_err ? RESP_SLVERR : RESP_OKAY;
		end else if (bready) begin
			bvalid <= 1'b0;
			wr_active <= 1'b0;
		end
	end

endmodule

// ==== rtl/axi_copy_engine.sv ====
`timescale 1ns/100ps
`include "copy_cfg.svh"

module axi_copy_engine
	import copy_pkg::*;
(
	input logic m_axi_aclk,
	input logic rst_n,

	// host command channel
	input logic cmd_valid,
	output logic cmd_ready,
	input logic [`COPY_ADDR_W-1:0] cmd_src_addr,
	input logic [`COPY_ADDR_W-1:0] cmd_dst_addr,
	input logic [LEN_W-1:0] cmd_len,
	input logic [`COPY_ID_W-1:0] cmd_id,

	// host done channel
	output logic done_valid,
	input logic done_ready,
	output logic [`COPY_ID_W-1:0] done_id,
	output logic [1:0] done_resp,

	output logic [`COPY_ADDR_W-1:0] m_axi_awaddr,
	output logic m_axi_awvalid,
	input logic m_axi_awready,
	output logic [`COPY_ID_W-1:0] m_axi_awid,
	output logic [7:0] m_axi_awlen,
	output logic [2:0] m_axi_awsize,
	output logic [1:0] m_axi_awburst,

	output logic [`COPY_ID_W-1:0] m_axi_wid,
	output logic [`COPY_DATA_W-1:0] m_axi_wdata,
	output logic [`COPY_DATA_W/8-1:0] m_axi_wstrb,
	output logic m_axi_wvalid,
	input logic m_axi_wready,
	output logic m_axi_wlast,

	output logic m_axi_bready,
	input logic [1:0] m_axi_bresp,
	input logic m_axi_bvalid,

	output logic [`COPY_ADDR_W-1:0] m_axi_araddr,
	output logic m_axi_arvalid,
	input logic m_axi_arready,
	output logic [`COPY_ID_W-1:0] m_axi_arid,
	output logic [7:0] m_axi_arlen,
	output logic [2:0] m_axi_arsize,
	output logic [1:0] m_axi_arburst,

	output logic m_axi_rready,
	input logic [`COPY_DATA_W-1:0] m_axi_rdata,
	input logic [1:0] m_axi_rresp,
	input logic m_axi_rvalid,
	input logic m_axi_rlast
);

	copy_cmd_t cmd_in;
	copy_cmd_t cmd_q_data;
	logic cmd_q_valid;
	logic cmd_q_ready;

	logic data_out_valid;
	logic w_enable;
	logic w_fire;
	logic r_fire;

	logic rd_load;
	logic wr_load;
	logic [LEN_W-1:0] beat_len;
	logic rd_last;
	logic wr_busy;

	assign cmd_in = '{
		src_addr: cmd_src_addr,
		dst_addr: cmd_dst_addr,
		len: cmd_len,
		id: cmd_id
	};

	// full-width incrementing bursts only
	assign m_axi_arsize = SIZE_WORD;
	assign m_axi_awsize = SIZE_WORD;
	assign m_axi_arburst = BURST_INCR;
	assign m_axi_awburst = BURST_INCR;
	assign m_axi_wstrb = '1;

	assign r_fire = m_axi_rvalid && m_axi_rready;
	assign m_axi_wvalid = data_out_valid && w_enable;
	assign w_fire = m_axi_wvalid && m_axi_wready;

	sync_fifo #(
		.payload_t(copy_cmd_t),
		.depth(`COPY_CMD_DEPTH)
	) cmd_fifo (
		.m_axi_aclk(m_axi_aclk),
		.rst_n(rst_n),
		.in_valid(cmd_valid),
		.in_data(cmd_in),
		.in_ready(cmd_ready),
		.out_valid(cmd_q_valid),
		.out_data(cmd_q_data),
		.out_ready(cmd_q_ready)
	);

	// R beats land here and drain on the W channel
	sync_fifo #(
		.payload_t(word_t),
		.depth(`COPY_BUF_DEPTH)
	) data_fifo (
		.m_axi_aclk(m_axi_aclk),
		.rst_n(rst_n),
		.in_valid(m_axi_rvalid),
		.in_data(m_axi_rdata),
		.in_ready(m_axi_rready),
		.out_valid(data_out_valid),
		.out_data(m_axi_wdata),
		.out_ready(m_axi_wready && w_enable)
	);

	beat_counter rd_beats (
		.m_axi_aclk(m_axi_aclk),
		.rst_n(rst_n),
		.load(rd_load),
		.load_len(beat_len),
		.step(r_fire),
		.last(rd_last),
		.busy()
	);

	beat_counter wr_beats (
		.m_axi_aclk(m_axi_aclk),
		.rst_n(rst_n),
		.load(wr_load),
		.load_len(beat_len),
		.step(w_fire),
		.last(m_axi_wlast),
		.busy(wr_busy)
	);

	copy_fsm fsm (
		.m_axi_aclk(m_axi_aclk),
		.rst_n(rst_n),
		.cmd_q_valid(cmd_q_valid),
		.cmd_q_data(cmd_q_data),
		.cmd_q_ready(cmd_q_ready),
		.rd_load(rd_load),
		.wr_load(wr_load),
		.beat_len(beat_len),
		.rd_last(rd_last),
		.wr_busy(wr_busy),
		.r_fire(r_fire),
		.rresp(m_axi_rresp),
		.rlast(m_axi_rlast),
		.w_enable(w_enable),
		.w_fire(w_fire),
		.araddr(m_axi_araddr),
		.arid(m_axi_arid),
		.arlen(m_axi_arlen),
		.arvalid(m_axi_arvalid),
		.arready(m_axi_arready),
		.awaddr(m_axi_awaddr),
		.awid(m_axi_awid),
		.awlen(m_axi_awlen),
		.awvalid(m_axi_awvalid),
		.awready(m_axi_awready),
		.wid(m_axi_wid),
		.bready(m_axi_bready),
		.bvalid(m_axi_bvalid),
		.bresp(m_axi_bresp),
		.done_valid(done_valid),
		.done_id(done_id),
		.done_resp(done_resp),
		.done_ready(done_ready)
	);

endmodule

// ==== rtl/copy_fsm.sv ====
`timescale 1ns/100ps
`include "copy_cfg.svh"

module copy_fsm
	import copy_pkg::*;
(
	input logic m_axi_aclk,
	input logic rst_n,

	input logic cmd_q_valid,
	input copy_cmd_t cmd_q_data,
	output logic cmd_q_ready,

	output logic rd_load,
	output logic wr_load,
	output logic [LEN_W-1:0] beat_len,
	input logic rd_last,
	input logic wr_busy,

	input logic r_fire,
	input logic [1:0] rresp,
	input logic rlast,

	output logic w_enable,
	input logic w_fire,

	output logic [`COPY_ADDR_W-1:0] araddr,
	output logic [`COPY_ID_W-1:0] arid,
	output logic [7:0] arlen,
	output logic arvalid,
	input logic arready,

	output logic [`COPY_ADDR_W-1:0] awaddr,
	output logic [`COPY_ID_W-1:0] awid,
	output logic [7:0] awlen,
	output logic awvalid,
	input logic awready,

	output logic [`COPY_ID_W-1:0] wid,

	output logic bready,
	input logic bvalid,
	input logic [1:0] bresp,

	output logic done_valid,
	output logic [`COPY_ID_W-1:0] done_id,
	output logic [1:0] done_resp,
	input logic done_ready
);

	typedef enum logic [2:0] {
		IDLE,
		AR,
		RDATA,
		AW,
		WDATA,
		BRESP,
		DONE
	} state_t;

	state_t state;
	copy_cmd_t cmd_r;
	logic pop;

	// first bad rresp of the burst, and any rlast mismatch
	resp_t rd_err;
	logic last_mismatch;
	resp_t done_resp_r;

	assign pop = cmd_q_valid && cmd_q_ready;
	assign cmd_q_ready = (state == IDLE);

	// both counters start from the popped length
	assign rd_load = pop;
	assign wr_load = pop;
	assign beat_len = cmd_q_data.len;

	assign arvalid = (state == AR);
	assign araddr = cmd_r.src_addr;
	assign arid = cmd_r.id;
	assign arlen = 8'(cmd_r.len) - 8'd1;

	assign awvalid = (state == AW);
	assign awaddr = cmd_r.dst_addr;
	assign awid = cmd_r.id;
	assign awlen = 8'(cmd_r.len) - 8'd1;

	assign w_enable = (state == WDATA);
	assign wid = cmd_r.id;

	assign bready = (state == BRESP);

	assign done_valid = (state == DONE);
	assign done_id = cmd_r.id;
	assign done_resp = done_resp_r;

	always_ff @(posedge m_axi_aclk) begin
		if (pop) begin
			cmd_r <= cmd_q_data;
		end
	end

	always_ff @(posedge m_axi_aclk) begin
		if (!rst_n) begin
			state <= IDLE;
		end else begin
			case (state)
				IDLE:
					if (pop) begin
						state <= AR;
					end
				AR:
					if (arready) begin
						state <= RDATA;
					end
				RDATA:
					if (r_fire && rd_last) begin
						state <= AW;
					end
				AW:
					if (awready) begin
						state <= WDATA;
					end
				// leave once the write counter has drained
				WDATA:
					if (!wr_busy) begin
						state <= BRESP;
					end
				BRESP:
					if (bvalid) begin
						state <= DONE;
					end
				DONE:
					if (done_ready) begin
						state <= IDLE;
					end
				default:
					state <= IDLE;
			endcase
		end
	end

	always_ff @(posedge m_axi_aclk) begin
		if (!rst_n) begin
			rd_err <= RESP_OKAY;
			last_mismatch <= 1'b0;
		end else if (pop) begin
			rd_err <= RESP_OKAY;
			last_mismatch <= 1'b0;
		end else if (r_fire) begin
			if (rd_err == RESP_OKAY && rresp != RESP_OKAY) begin
				rd_err <= resp_t'(rresp);
			end
			if (rlast != rd_last) begin
				last_mismatch <= 1'b1;
			end
		end
	end

	// write error wins, then read error, then a framing error
	always_ff @(posedge m_axi_aclk) begin
		if (bvalid && bready) begin
			if (bresp != RESP_OKAY) begin
				done_resp_r <= resp_t'(bresp);
			end else if (rd_err != RESP_OKAY) begin
				done_resp_r <= rd_err;
			end else if (last_mismatch) begin
				done_resp_r <= RESP_SLVERR;
			end else begin
				done_resp_r <= RESP_OKAY;
			end
		end
	end

endmodule

// ==== rtl/beat_counter.sv ====
`timescale 1ns/100ps
`include "copy_cfg.svh"

module beat_counter
	import copy_pkg::*;
(
	input logic m_axi_aclk,
	input logic rst_n,
	input logic load,
	input logic [LEN_W-1:0] load_len,
	input logic step,
	output logic last,
	output logic busy
);

	// beats still to go in the current burst
	logic [LEN_W-1:0] remaining;

	assign busy = (remaining != '0);
	assign last = (remaining == LEN_W'(1));

	always_ff @(posedge m_axi_aclk) begin
		if (!rst_n) begin
			remaining <= '0;
		end else if (load) begin
			remaining <= load_len;
		end else if (step && busy) begin
			remaining <= remaining - 1'b1;
		end
	end

endmodule

// ==== rtl/sync_fifo.sv ====
`timescale 1ns/100ps
`include "copy_cfg.svh"

module sync_fifo
	import copy_pkg::*;
#(
	parameter type payload_t = word_t,
	parameter int depth = `COPY_BUF_DEPTH
) (
	input logic m_axi_aclk,
	input logic rst_n,

	input logic in_valid,
	input payload_t in_data,
	output logic in_ready,

	output logic out_valid,
	output payload_t out_data,
	input logic out_ready
);

	localparam int ptr_w = (depth > 1) ? $clog2(depth) : 1;
	localparam int cnt_w = $clog2(depth + 1);

	payload_t mem [depth];
	logic [ptr_w-1:0] wr_ptr;
	logic [ptr_w-1:0] rd_ptr;
	logic [cnt_w-1:0] count;
	logic push;
	logic pop;

	assign in_ready = (count != cnt_w'(depth));
	assign out_valid = (count != '0);
	assign out_data = mem[rd_ptr];

	assign push = in_valid && in_ready;
	assign pop = out_valid && out_ready;

	always_ff @(posedge m_axi_aclk) begin
		if (push) begin
			mem[wr_ptr] <= in_data;
		end
	end

	always_ff @(posedge m_axi_aclk) begin
		if (!rst_n) begin
			wr_ptr <= '0;
			rd_ptr <= '0;
			count <= '0;
		end else begin
			if (push) begin
				wr_ptr <= (wr_ptr == ptr_w'(depth - 1)) ? '0 : wr_ptr + 1'b1;
			end
			if (pop) begin
				rd_ptr <= (rd_ptr == ptr_w'(depth - 1)) ? '0 : rd_ptr + 1'b1;
			end
			// simultaneous push and pop leave the count alone
			if (push && !pop) begin
				count <= count + 1'b1;
			end else if (pop && !push) begin
				count <= count - 1'b1;
			end
		end
	end

endmodule

// ==== rtl/copy_pkg.sv ====
`include "copy_cfg.svh"

package copy_pkg;

	// width of a beat count, 1 to COPY_MAX_LEN
	localparam int LEN_W = $clog2(`COPY_MAX_LEN + 1);

	typedef logic [`COPY_DATA_W-1:0] word_t;

	typedef struct packed {
		logic [`COPY_ADDR_W-1:0] src_addr;
		logic [`COPY_ADDR_W-1:0] dst_addr;
		logic [LEN_W-1:0] len;
		logic [`COPY_ID_W-1:0] id;
	} copy_cmd_t;

	typedef enum logic [1:0] {
		RESP_OKAY = 2'd0,
		RESP_EXOKAY = 2'd1,
		RESP_SLVERR = 2'd2,
		RESP_DECERR = 2'd3
	} resp_t;

	localparam logic [1:0] BURST_INCR = 2'b01;

	// log2 of bytes per beat
	localparam logic [2:0] SIZE_WORD = 3'($clog2(`COPY_DATA_W / 8));

endpackage

// ==== include/copy_cfg.svh ====
`ifndef COPY_CFG_SVH
`define COPY_CFG_SVH

// byte address width
`define COPY_ADDR_W 32

// width of one beat, all strobes set
`define COPY_DATA_W 32

`define COPY_ID_W 4

// longest burst in beats
`define COPY_MAX_LEN 16

// waiting commands
`define COPY_CMD_DEPTH 4

// holds a whole read burst, keep >= COPY_MAX_LEN
`define COPY_BUF_DEPTH 16

`endif
